// ==== kbd_config.svh ====
`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

// Bus address width in bits
`define KBD_ADDR_WIDTH 16

// Register block base and byte offsets
`define KBD_BASE       16'h1000
`define KBD_DATA_OFS   0
`define KBD_STATUS_OFS 4
`define KBD_CTRL_OFS   8

// Event queue entries and pointer width
`define KBD_FIFO_DEPTH 8
`define KBD_FIFO_AW    3

// Vector number raised for a new key event
`define KBD_IRQ_VECTOR 1

`endif

// ==== kbd_pkg.sv ====
`default_nettype none

`include "kbd_config.svh"

package kbd_pkg;

    // Plain vectors with a meaning
    typedef logic [7:0]                   scan_code_t;
    typedef logic [7:0]                   ascii_t;
    typedef logic [`KBD_ADDR_WIDTH-1:0]   bus_addr_t;
    typedef logic [31:0]                  bus_data_t;
    typedef logic [3:0]                   irq_vector_t;
    typedef logic [`KBD_FIFO_AW:0]        fifo_count_t;

    // Checked PS/2 frame, only the data byte survives
    typedef struct packed {
        scan_code_t scan;
    } ps2_frame_t;

    // Key event as queued, 18 bits
    typedef struct packed {
        logic       extended;
        logic       released;
        scan_code_t scan;
        ascii_t     ascii;
    } key_event_t;

    // PS/2 receiver FSM
    typedef enum logic [1:0] {
        IDLE,
        DATA,
        PARITY,
        STOP
    } rx_state_t;

endpackage

`default_nettype wire

// ==== ps2_frame_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_rx (
    input  wire                 CLOCK_50,
    input  wire                 KEY0,
    input  wire                 ps2_clk,
    input  wire                 ps2_dat,
    input  wire                 frame_ready,
    output logic                frame_valid,
    output kbd_pkg::ps2_frame_t frame,
    output logic                overrun_pulse,
    output logic                parity_err_pulse
);

    logic [1:0]          clk_sync;
    logic [1:0]          dat_sync;
    logic                clk_prev;
    logic                fall;
    kbd_pkg::rx_state_t  state;
    logic [2:0]          bit_cnt;
    kbd_pkg::scan_code_t shift;
    logic                par_bit;
    logic                frame_done;
    logic                frame_ok;
    logic                load;

    // Two-flop synchronizers, lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // Keyboard data is stable on the falling clock edge
    assign fall = clk_prev & ~clk_sync[1];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= kbd_pkg::IDLE;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
            frame_ok   <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (fall) begin
                case (state)
                    kbd_pkg::IDLE: begin
                        if (!dat_sync[1]) begin
                            state   <= kbd_pkg::DATA;
                            bit_cnt <= '0;
                        end else begin
                            // High start bit, report as frame error
                            frame_done <= 1'b1;
                            frame_ok   <= 1'b0;
                        end
                    end
                    kbd_pkg::DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= kbd_pkg::PARITY;
                        end
                    end
                    kbd_pkg::PARITY: begin
                        state <= kbd_pkg::STOP;
                    end
                    default: begin
                        // Odd parity over data and parity bit, stop must be high
                        frame_done <= 1'b1;
                        frame_ok   <= dat_sync[1] & (^{shift, par_bit});
                        state      <= kbd_pkg::IDLE;
                    end
                endcase
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge CLOCK_50) begin
        if (fall && state == kbd_pkg::DATA) begin
            shift <= {dat_sync[1], shift[7:1]};
        end
        if (fall && state == kbd_pkg::PARITY) begin
            par_bit <= dat_sync[1];
        end
    end

    // Output register is free or being emptied this cycle
    assign load = frame_done & frame_ok & (~frame_valid | frame_ready);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            frame_valid      <= 1'b0;
            overrun_pulse    <= 1'b0;
            parity_err_pulse <= 1'b0;
        end else begin
            overrun_pulse    <= frame_done & frame_ok & ~load;
            parity_err_pulse <= frame_done & ~frame_ok;
            if (load) begin
                frame_valid <= 1'b1;
            end else if (frame_ready) begin
                frame_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (load) begin
            frame.scan <= shift;
        end
    end

endmodule

`default_nettype wire

// ==== scan_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_decoder (
    input  wire                      CLOCK_50,
    input  wire                      KEY0,
    input  wire                      frame_valid,
    input  wire kbd_pkg::ps2_frame_t frame,
    input  wire                      report_release,
    input  wire                      evt_ready,
    output logic                     frame_ready,
    output logic                     evt_valid,
    output kbd_pkg::key_event_t      evt
);

    // Set-2 prefix bytes
    localparam kbd_pkg::scan_code_t BREAK_CODE = 8'hF0;
    localparam kbd_pkg::scan_code_t EXT_CODE   = 8'hE0;

    logic            brk_seen;
    logic            ext_seen;
    logic            take;
    logic            is_prefix;
    logic            emit;
    kbd_pkg::ascii_t ascii;

    // A waiting event blocks the next frame
    assign frame_ready = ~evt_valid | evt_ready;
    assign take        = frame_valid & frame_ready;
    assign is_prefix   = (frame.scan == BREAK_CODE) | (frame.scan == EXT_CODE);
    assign emit        = ~is_prefix & (~brk_seen | report_release);

    // Set-2 table, extended codes carry no ASCII
    always_comb begin
        ascii = 8'h00;
        if (!ext_seen) begin
            case (frame.scan)
                8'h1C:   ascii = "a";
                8'h32:   ascii = "b";
                8'h21:   ascii = "c";
                8'h23:   ascii = "d";
                8'h24:   ascii = "e";
                8'h2B:   ascii = "f";
                8'h34:   ascii = "g";
                8'h33:   ascii = "h";
                8'h43:   ascii = "i";
                8'h3B:   ascii = "j";
                8'h42:   ascii = "k";
                8'h4B:   ascii = "l";
                8'h3A:   ascii = "m";
                8'h31:   ascii = "n";
                8'h44:   ascii = "o";
                8'h4D:   ascii = "p";
                8'h15:   ascii = "q";
                8'h2D:   ascii = "r";
                8'h1B:   ascii = "s";
                8'h2C:   ascii = "t";
                8'h3C:   ascii = "u";
                8'h2A:   ascii = "v";
                8'h1D:   ascii = "w";
                8'h22:   ascii = "x";
                8'h35:   ascii = "y";
                8'h1A:   ascii = "z";
                8'h45:   ascii = "0";
                8'h16:   ascii = "1";
                8'h1E:   ascii = "2";
                8'h26:   ascii = "3";
                8'h25:   ascii = "4";
                8'h2E:   ascii = "5";
                8'h36:   ascii = "6";
                8'h3D:   ascii = "7";
                8'h3E:   ascii = "8";
                8'h46:   ascii = "9";
                8'h29:   ascii = 8'h20;
                8'h5A:   ascii = 8'h0D;
                8'h66:   ascii = 8'h08;
                default: ascii = 8'h00;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            brk_seen  <= 1'b0;
            ext_seen  <= 1'b0;
            evt_valid <= 1'b0;
            evt       <= '0;
        end else if (take) begin
            if (frame.scan == BREAK_CODE) begin
                brk_seen <= 1'b1;
            end else if (frame.scan == EXT_CODE) begin
                ext_seen <= 1'b1;
            end else begin
                brk_seen <= 1'b0;
                ext_seen <= 1'b0;
            end
            // Prefixes and unreported releases leave no event
            evt_valid <= emit;
            if (emit) begin
                evt.extended <= ext_seen;
                evt.released <= brk_seen;
                evt.scan     <= frame.scan;
                evt.ascii    <= ascii;
            end
        end else if (evt_ready) begin
            evt_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== key_event_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kbd_config.svh"

module key_event_fifo (
    input  wire                  CLOCK_50,
    input  wire                  KEY0,
    input  wire                  evt_valid,
    input  wire kbd_pkg::key_event_t evt,
    input  wire                  pop,
    output logic                 evt_ready,
    output kbd_pkg::key_event_t  head,
    output kbd_pkg::fifo_count_t count,
    output logic                 empty,
    output logic                 pushed
);

    kbd_pkg::key_event_t    mem [`KBD_FIFO_DEPTH];
    logic [`KBD_FIFO_AW-1:0] wr_ptr;
    logic [`KBD_FIFO_AW-1:0] rd_ptr;
    logic                   push;
    logic                   do_pop;

    // Back-pressure only when full
    assign evt_ready = (count != kbd_pkg::fifo_count_t'(`KBD_FIFO_DEPTH));
    assign empty     = (count == '0);
    assign head      = mem[rd_ptr];
    assign push      = evt_valid & evt_ready;
    assign do_pop    = pop & ~empty;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            pushed <= 1'b0;
        end else begin
            pushed <= push;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (push) begin
            mem[wr_ptr] <= evt;
        end
    end

endmodule

`default_nettype wire

// ==== kbd_bus_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kbd_config.svh"

module kbd_bus_regs (
    input  wire                       CLOCK_50,
    input  wire                       KEY0,
    input  wire kbd_pkg::bus_addr_t   address,
    input  wire                       read_enable,
    input  wire                       write_enable,
    input  wire kbd_pkg::bus_data_t   write_data,
    input  wire kbd_pkg::key_event_t  head,
    input  wire kbd_pkg::fifo_count_t count,
    input  wire                       empty,
    input  wire                       pushed,
    input  wire                       overrun_pulse,
    input  wire                       parity_err_pulse,
    input  wire                       interrupt_ack,
    output kbd_pkg::bus_data_t        read_data,
    output logic                      pop,
    output logic                      report_release,
    output kbd_pkg::irq_vector_t      interrupt_vector
);

    localparam kbd_pkg::bus_addr_t DATA_ADDR   = `KBD_BASE + `KBD_DATA_OFS;
    localparam kbd_pkg::bus_addr_t STATUS_ADDR = `KBD_BASE + `KBD_STATUS_OFS;
    localparam kbd_pkg::bus_addr_t CTRL_ADDR   = `KBD_BASE + `KBD_CTRL_OFS;

    logic               irq_enable;
    logic               overrun_flag;
    logic               frame_err_flag;
    logic               status_rd;
    logic               ctrl_wr;
    kbd_pkg::bus_data_t rd_mux;

    assign pop       = read_enable & (address == DATA_ADDR) & ~empty;
    assign status_rd = read_enable & (address == STATUS_ADDR);
    assign ctrl_wr   = write_enable & (address == CTRL_ADDR);

    always_comb begin
        rd_mux = '0;
        case (address)
            DATA_ADDR: begin
                // Bit 31 marks a real event, an empty queue reads as zero
                if (!empty) begin
                    rd_mux = {1'b1, 13'd0, head.extended, head.released, head.scan, head.ascii};
                end
            end
            STATUS_ADDR: rd_mux = {22'd0, frame_err_flag, overrun_flag, 4'd0, count};
            CTRL_ADDR:   rd_mux = {30'd0, report_release, irq_enable};
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_data        <= '0;
            irq_enable       <= 1'b0;
            report_release   <= 1'b0;
            overrun_flag     <= 1'b0;
            frame_err_flag   <= 1'b0;
            interrupt_vector <= '0;
        end else begin
            read_data <= read_enable ? rd_mux : '0;
            if (ctrl_wr) begin
                irq_enable     <= write_data[0];
                report_release <= write_data[1];
            end
            // A new error in the same cycle as the STATUS read stays set
            if (overrun_pulse) begin
                overrun_flag <= 1'b1;
            end else if (status_rd) begin
                overrun_flag <= 1'b0;
            end
            if (parity_err_pulse) begin
                frame_err_flag <= 1'b1;
            end else if (status_rd) begin
                frame_err_flag <= 1'b0;
            end
            // One-shot vector, raised only by a fresh push
            if (interrupt_vector != '0 && interrupt_ack) begin
                interrupt_vector <= '0;
            end else if (pushed && irq_enable && interrupt_vector == '0) begin
                interrupt_vector <= kbd_pkg::irq_vector_t'(`KBD_IRQ_VECTOR);
            end
        end
    end

endmodule

`default_nettype wire

// ==== kbd_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbd_subsystem (
    input  wire                     CLOCK_50,
    input  wire                     KEY0,
    input  wire                     ps2_clk,
    input  wire                     ps2_dat,
    input  wire kbd_pkg::bus_addr_t address,
    input  wire                     read_enable,
    input  wire                     write_enable,
    input  wire kbd_pkg::bus_data_t write_data,
    input  wire                     interrupt_ack,
    output kbd_pkg::bus_data_t      read_data,
    output kbd_pkg::irq_vector_t    interrupt_vector
);

    // Receiver to decoder
    wire                       frame_valid;
    wire                       frame_ready;
    kbd_pkg::ps2_frame_t       frame;
    wire                       overrun_pulse;
    wire                       parity_err_pulse;

    // Decoder to queue
    wire                       evt_valid;
    wire                       evt_ready;
    kbd_pkg::key_event_t       evt;

    // Queue to register block
    kbd_pkg::key_event_t       head;
    kbd_pkg::fifo_count_t      count;
    wire                       empty;
    wire                       pushed;
    wire                       pop;
    wire                       report_release;

    ps2_frame_rx u_rx (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .ps2_clk          (ps2_clk),
        .ps2_dat          (ps2_dat),
        .frame_ready      (frame_ready),
        .frame_valid      (frame_valid),
        .frame            (frame),
        .overrun_pulse    (overrun_pulse),
        .parity_err_pulse (parity_err_pulse)
    );

    scan_decoder u_dec (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .frame_valid    (frame_valid),
        .frame          (frame),
        .report_release (report_release),
        .evt_ready      (evt_ready),
        .frame_ready    (frame_ready),
        .evt_valid      (evt_valid),
        .evt            (evt)
    );

    key_event_fifo u_fifo (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .evt_valid (evt_valid),
        .evt       (evt),
        .pop       (pop),
        .evt_ready (evt_ready),
        .head      (head),
        .count     (count),
        .empty     (empty),
        .pushed    (pushed)
    );

    kbd_bus_regs u_regs (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .address          (address),
        .read_enable      (read_enable),
        .write_enable     (write_enable),
        .write_data       (write_data),
        .head             (head),
        .count            (count),
        .empty            (empty),
        .pushed           (pushed),
        .overrun_pulse    (overrun_pulse),
        .parity_err_pulse (parity_err_pulse),
        .interrupt_ack    (interrupt_ack),
        .read_data        (read_data),
        .pop              (pop),
        .report_release   (report_release),
        .interrupt_vector (interrupt_vector)
    );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic CLOCK_50,
    output logic KEY0
);

    // 10 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    // Reset held for 4 cycles, released mid-cycle
    initial begin
        KEY0 = 1'b0;
        repeat (4) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
    end

endmodule

`default_nettype wire

// ==== kbd_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kbd_config.svh"

module kbd_checker (
    input  wire                       CLOCK_50,
    input  wire                       KEY0,
    input  wire kbd_pkg::bus_addr_t   address,
    input  wire                       read_enable,
    input  wire                       write_enable,
    input  wire kbd_pkg::bus_data_t   write_data,
    input  wire                       interrupt_ack,
    input  wire kbd_pkg::bus_data_t   read_data,
    input  wire kbd_pkg::irq_vector_t interrupt_vector,
    input  wire                       evt_entered,
    input  wire                       exp_check,
    input  wire kbd_pkg::bus_data_t   exp_data,
    output integer                    check_count,
    output integer                    error_count
);

    kbd_pkg::irq_vector_t model_vec;
    kbd_pkg::irq_vector_t next_vec;
    logic                 ien;
    logic                 entered_last;
    logic                 pending;
    kbd_pkg::bus_data_t   pending_exp;
    kbd_pkg::bus_addr_t   pending_addr;

    // Sampled mid-cycle, away from the driving and clocking edges
    always @(negedge CLOCK_50) begin
        if (KEY0 !== 1'b1) begin
            model_vec    = '0;
            ien          = 1'b0;
            entered_last = 1'b0;
            pending      = 1'b0;
            check_count  = 0;
            error_count  = 0;
        end else begin
            if (interrupt_vector !== model_vec) begin
                $display("FAIL t=%0t: interrupt_vector is %0d, expected %0d",
                         $time, interrupt_vector, model_vec);
                error_count = error_count + 1;
                model_vec   = interrupt_vector;
            end

            // Read data arrives one cycle after read_enable
            if (pending) begin
                check_count = check_count + 1;
                if (read_data !== pending_exp) begin
                    $display("FAIL t=%0t: read of %h returned %h, expected %h",
                             $time, pending_addr, read_data, pending_exp);
                    error_count = error_count + 1;
                end
            end

            // One-shot vector, acknowledge wins over a new event
            next_vec = model_vec;
            if (model_vec != '0 && interrupt_ack) begin
                next_vec = '0;
            end else if (entered_last && ien && model_vec == '0) begin
                next_vec = kbd_pkg::irq_vector_t'(`KBD_IRQ_VECTOR);
            end
            model_vec    = next_vec;
            entered_last = evt_entered;

            if (write_enable && address == kbd_pkg::bus_addr_t'(`KBD_BASE + `KBD_CTRL_OFS)) begin
                ien = write_data[0];
            end

            pending      = read_enable & exp_check;
            pending_exp  = exp_data;
            pending_addr = address;
        end
    end

endmodule

`default_nettype wire

// ==== kbd_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kbd_config.svh"

module kbd_assert (
    input  wire                       CLOCK_50,
    input  wire                       KEY0,
    input  wire                       frame_valid,
    input  wire                       frame_ready,
    input  wire                       evt_valid,
    input  wire                       evt_ready,
    input  wire kbd_pkg::key_event_t  evt,
    input  wire kbd_pkg::fifo_count_t count,
    input  wire kbd_pkg::irq_vector_t interrupt_vector,
    input  wire                       interrupt_ack
);

    // Number of assertion failures so far
    integer fail_count = 0;

    frame_held: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        frame_valid && !frame_ready |=> frame_valid)
        else begin
            fail_count = fail_count + 1;
            $error("frame_valid dropped before a transfer");
        end

    evt_held: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        evt_valid && !evt_ready |=> evt_valid && $stable(evt))
        else begin
            fail_count = fail_count + 1;
            $error("evt changed or dropped before a transfer");
        end

    count_bound: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        count <= kbd_pkg::fifo_count_t'(`KBD_FIFO_DEPTH))
        else begin
            fail_count = fail_count + 1;
            $error("queue count above its depth");
        end

    irq_cleared: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        interrupt_vector != '0 && interrupt_ack |=> interrupt_vector == '0)
        else begin
            fail_count = fail_count + 1;
            $error("interrupt_vector not cleared after acknowledge");
        end

endmodule

bind kbd_subsystem kbd_assert u_assert (
    .CLOCK_50         (CLOCK_50),
    .KEY0             (KEY0),
    .frame_valid      (frame_valid),
    .frame_ready      (frame_ready),
    .evt_valid        (evt_valid),
    .evt_ready        (evt_ready),
    .evt              (evt),
    .count            (count),
    .interrupt_vector (interrupt_vector),
    .interrupt_ack    (interrupt_ack)
);

`default_nettype wire

// ==== kbd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kbd_config.svh"

module kbd_tb;

    localparam integer TIMEOUT_CYCLES = 2000;
    localparam integer BIT_CYCLES     = 20;
    localparam integer GAP_CYCLES     = 40;

    wire                  CLOCK_50;
    wire                  KEY0;
    logic                 ps2_clk;
    logic                 ps2_dat;
    kbd_pkg::bus_addr_t   address;
    logic                 read_enable;
    logic                 write_enable;
    kbd_pkg::bus_data_t   write_data;
    logic                 interrupt_ack;
    kbd_pkg::bus_data_t   read_data;
    kbd_pkg::irq_vector_t interrupt_vector;
    logic                 exp_check;
    kbd_pkg::bus_data_t   exp_data;
    integer               check_count;
    integer               error_count;

    integer             fd;
    integer             code;
    integer             cycles;
    reg [8*8-1:0]       kind;
    reg [8*80-1:0]      line;
    logic [31:0]        arg_a;
    logic [31:0]        arg_b;
    integer             test_num;
    integer             test_base;
    integer             test_total;
    integer             timeouts;
    logic               aborted;
    logic               done;
    kbd_pkg::bus_data_t rd_value;

    tb_clock u_clock (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    kbd_subsystem dut (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .ps2_clk          (ps2_clk),
        .ps2_dat          (ps2_dat),
        .address          (address),
        .read_enable      (read_enable),
        .write_enable     (write_enable),
        .write_data       (write_data),
        .interrupt_ack    (interrupt_ack),
        .read_data        (read_data),
        .interrupt_vector (interrupt_vector)
    );

    kbd_checker u_checker (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .address          (address),
        .read_enable      (read_enable),
        .write_enable     (write_enable),
        .write_data       (write_data),
        .interrupt_ack    (interrupt_ack),
        .read_data        (read_data),
        .interrupt_vector (interrupt_vector),
        .evt_entered      (dut.evt_valid & dut.evt_ready),
        .exp_check        (exp_check),
        .exp_data         (exp_data),
        .check_count      (check_count),
        .error_count      (error_count)
    );

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle(input integer n);
        repeat (n) begin
            @(posedge CLOCK_50);
            #1;
        end
    endtask

    // Start, 8 data bits LSB first, odd parity, stop
    task automatic send_key(input logic [7:0] value, input logic corrupt);
        logic [10:0] bits;
        integer      i;
        bits = {1'b1, (~^value) ^ corrupt, value, 1'b0};
        for (i = 0; i < 11; i = i + 1) begin
            ps2_dat = bits[i];
            next_cycle(BIT_CYCLES / 2);
            ps2_clk = 1'b0;
            next_cycle(BIT_CYCLES / 2);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        next_cycle(GAP_CYCLES);
    endtask

    task automatic bus_write(input kbd_pkg::bus_addr_t addr, input kbd_pkg::bus_data_t data);
        address      = addr;
        write_data   = data;
        write_enable = 1'b1;
        next_cycle(1);
        write_enable = 1'b0;
        write_data   = '0;
    endtask

    task automatic bus_read(input kbd_pkg::bus_addr_t addr, input logic check,
                            input kbd_pkg::bus_data_t expect_val,
                            output kbd_pkg::bus_data_t value);
        address     = addr;
        read_enable = 1'b1;
        exp_check   = check;
        exp_data    = expect_val;
        next_cycle(1);
        value       = read_data;
        read_enable = 1'b0;
        exp_check   = 1'b0;
    endtask

    // Polls STATUS until the queue holds n events
    task automatic wait_count(input logic [3:0] n);
        integer             waited;
        kbd_pkg::bus_data_t status;
        waited = 0;
        bus_read(`KBD_BASE + `KBD_STATUS_OFS, 1'b0, '0, status);
        while (status[3:0] !== n && waited < TIMEOUT_CYCLES) begin
            next_cycle(1);
            bus_read(`KBD_BASE + `KBD_STATUS_OFS, 1'b0, '0, status);
            waited = waited + 2;
        end
        if (status[3:0] !== n) begin
            $display("Timeout: STATUS count did not reach %0d within %0d cycles",
                     n, TIMEOUT_CYCLES);
            timeouts = timeouts + 1;
            aborted  = 1'b1;
        end
    endtask

    task automatic close_test;
        integer errs;
        errs = error_count + timeouts + dut.u_assert.fail_count - test_base;
        if (test_num > 0) begin
            if (errs == 0) begin
                $display("test %0d: done, no errors", test_num);
            end else begin
                $display("test %0d: done, %0d errors", test_num, errs);
            end
        end
        test_base = error_count + timeouts + dut.u_assert.fail_count;
    endtask

    initial begin
        ps2_clk       = 1'b1;
        ps2_dat       = 1'b1;
        address       = '0;
        read_enable   = 1'b0;
        write_enable  = 1'b0;
        write_data    = '0;
        interrupt_ack = 1'b0;
        exp_check     = 1'b0;
        exp_data      = '0;
        test_num      = 0;
        test_base     = 0;
        test_total    = 0;
        timeouts      = 0;
        aborted       = 1'b0;
        done          = 1'b0;

        fd = $fopen("kbd_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open kbd_vectors.txt");
            aborted = 1'b1;
        end

        cycles = 0;
        while (KEY0 !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            next_cycle(1);
            cycles = cycles + 1;
        end
        if (KEY0 !== 1'b1) begin
            $display("Timeout: reset was never released");
            aborted = 1'b1;
        end
        next_cycle(2);

        while (!aborted && !done) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                $display("Vector file ended without an END record");
                aborted = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(line, fd);
            end else if (kind == "TEST") begin
                close_test;
                code       = $fscanf(fd, "%h", arg_a);
                test_num   = arg_a;
                test_total = test_total + 1;
            end else if (kind == "KEY") begin
                code = $fscanf(fd, "%h %h", arg_a, arg_b);
                send_key(arg_a[7:0], arg_b[0]);
            end else if (kind == "WR") begin
                code = $fscanf(fd, "%h %h", arg_a, arg_b);
                bus_write(arg_a[`KBD_ADDR_WIDTH-1:0], arg_b);
            end else if (kind == "RD") begin
                code = $fscanf(fd, "%h %h", arg_a, arg_b);
                bus_read(arg_a[`KBD_ADDR_WIDTH-1:0], 1'b1, arg_b, rd_value);
                next_cycle(1);
            end else if (kind == "ACK") begin
                interrupt_ack = 1'b1;
                next_cycle(1);
                interrupt_ack = 1'b0;
                next_cycle(1);
            end else if (kind == "WAITQ") begin
                code = $fscanf(fd, "%h", arg_a);
                wait_count(arg_a[3:0]);
            end else if (kind == "END") begin
                close_test;
                done = 1'b1;
            end else begin
                $display("Unknown record %0s in kbd_vectors.txt", kind);
                aborted = 1'b1;
            end
        end

        // Lets the last read comparison happen
        next_cycle(4);
        $display("Summary: %0d tests, %0d reads checked, %0d errors, %0d assertion failures, %0d timeouts",
                 test_total, check_count, error_count, dut.u_assert.fail_count, timeouts);
        if (!aborted && error_count == 0 && dut.u_assert.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== kbd_vectors.txt ====
# Records: KEY byte corrupt | WR addr data | RD addr expect | WAITQ count
# ACK | TEST number | END, every number in hex
TEST 1
KEY 1c 0
KEY 32 0
KEY 45 0
WAITQ 3
RD 1000 80001c61
RD 1000 80003262
RD 1000 80004530
RD 1000 00000000
TEST 2
KEY f0 0
KEY 1c 0
KEY e0 0
KEY 75 0
WAITQ 1
RD 1000 80027500
RD 1000 00000000
WR 1008 00000002
KEY f0 0
KEY 1c 0
WAITQ 1
RD 1000 80011c61
WR 1008 00000000
TEST 3
WR 1008 00000001
KEY 1c 0
WAITQ 1
KEY 32 0
WAITQ 2
ACK
KEY 21 0
WAITQ 3
ACK
RD 1000 80001c61
RD 1000 80003262
RD 1000 80002163
WR 1008 00000000
TEST 4
KEY 1c 1
RD 1004 00000200
RD 1004 00000000
TEST 5
# Eight fill the queue, two wait in the pipeline, the eleventh overruns
KEY 1c 0
KEY 32 0
KEY 21 0
KEY 23 0
KEY 24 0
KEY 2b 0
KEY 34 0
KEY 33 0
KEY 43 0
KEY 3b 0
KEY 42 0
RD 1004 00000108
RD 1000 80001c61
RD 1000 80003262
RD 1000 80002163
RD 1000 80002364
RD 1000 80002465
RD 1000 80002b66
RD 1000 80003467
RD 1000 80003368
WAITQ 2
RD 1000 80004369
RD 1000 80003b6a
RD 1000 00000000
RD 1004 00000000
TEST 6
WR 1008 00000003
RD 1008 00000003
WR 1008 00000001
RD 1008 00000001
WR 1008 00000000
RD 1008 00000000
RD 100c 00000000
RD 2000 00000000
END

// ==== sources.f ====
+incdir+.
kbd_pkg.sv
ps2_frame_rx.sv
scan_decoder.sv
key_event_fifo.sv
kbd_bus_regs.sv
kbd_subsystem.sv
tb_clock.sv
kbd_checker.sv
kbd_assert.sv
kbd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the keyboard testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module kbd_tb -o kbd_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build did not complete, see build.log"
    exit 1
fi

./obj_dir/kbd_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0
